// ==== bitmanip_unit.sv ====
// Single-stage bit-manipulation unit with leading-zero count,
// population count and rotate left
`timescale 1ns/1ps

module bitmanip_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  offload_pkg::acc_req_t  req_i,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output offload_pkg::acc_resp_t resp_o
);
  import offload_pkg::*;

  localparam int ShWidth  = $clog2(DataWidth);
  localparam int CntWidth = ShWidth + 1;

  logic                   out_valid_q;
  id_t                    out_id_q;
  logic [DataWidth-1:0]   out_data_q;
  logic                   out_error_q;

  logic [CntWidth-1:0]    clz_cnt;
  logic [CntWidth-1:0]    cpop_cnt;
  logic [2*DataWidth-1:0] rol_wide;
  logic [DataWidth-1:0]   res_data;
  logic                   res_error;

  always_comb begin
    // Highest set bit wins, all zero gives the full width
    clz_cnt  = CntWidth'(DataWidth);
    cpop_cnt = '0;
    for (int i = 0; i < DataWidth; i++) begin
      if (req_i.arga[i]) begin
        clz_cnt = CntWidth'(DataWidth - 1 - i);
      end
      cpop_cnt = cpop_cnt + CntWidth'(req_i.arga[i]);
    end
  end

  // Upper half of the doubled word is the rotated operand
  assign rol_wide = {req_i.arga, req_i.arga} << req_i.argb[ShWidth-1:0];

  always_comb begin
    res_error = 1'b0;
    case (req_i.op)
      BitClz:  res_data = DataWidth'(clz_cnt);
      BitCpop: res_data = DataWidth'(cpop_cnt);
      BitRol:  res_data = rol_wide[2*DataWidth-1:DataWidth];
      default: begin
        res_data  = '0;
        res_error = 1'b1;
      end
    endcase
  end

  assign req_ready_o = !out_valid_q || resp_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      out_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      out_id_q    <= req_i.id;
      out_data_q  <= res_data;
      out_error_q <= res_error;
    end
  end

  assign resp_valid_o = out_valid_q;
  assign resp_o.id    = out_id_q;
  assign resp_o.data  = out_data_q;
  assign resp_o.error = out_error_q;

endmodule

// ==== mul_unit.sv ====
// Two-stage pipelined 32x32 multiplier returning the low word
// or one of the signed, mixed or unsigned high words
`timescale 1ns/1ps

module mul_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  offload_pkg::acc_req_t  req_i,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output offload_pkg::acc_resp_t resp_o
);
  import offload_pkg::*;

  // Stage one holds sign-extended operands
  logic                 s1_valid_q;
  id_t                  s1_id_q;
  logic                 s1_hi_q;
  logic [DataWidth:0]   s1_a_q;
  logic [DataWidth:0]   s1_b_q;
  // Stage two holds the full product
  logic                 s2_valid_q;
  id_t                  s2_id_q;
  logic                 s2_hi_q;
  logic [2*DataWidth-1:0] s2_prod_q;

  logic                 a_signed;
  logic                 b_signed;
  logic                 s1_ready;
  logic                 s2_ready;
  logic signed [2*DataWidth+1:0] prod_full;

  assign a_signed = (req_i.op == MulHiSS) || (req_i.op == MulHiSU);
  assign b_signed = (req_i.op == MulHiSS);

  // A stage advances when the next one is empty or moving
  assign s2_ready    = !s2_valid_q || resp_ready_i;
  assign s1_ready    = !s1_valid_q || s2_ready;
  assign req_ready_o = s1_ready;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= req_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  assign prod_full = $signed(s1_a_q) * $signed(s1_b_q);

  always_ff @(posedge clk_i) begin
    if (req_valid_i && s1_ready) begin
      s1_id_q <= req_i.id;
      s1_hi_q <= (req_i.op != MulLo);
      s1_a_q  <= {a_signed & req_i.arga[DataWidth-1], req_i.arga};
      s1_b_q  <= {b_signed & req_i.argb[DataWidth-1], req_i.argb};
    end
    if (s1_valid_q && s2_ready) begin
      s2_id_q   <= s1_id_q;
      s2_hi_q   <= s1_hi_q;
      s2_prod_q <= prod_full[2*DataWidth-1:0];
    end
  end

  assign resp_valid_o = s2_valid_q;
  assign resp_o.id    = s2_id_q;
  assign resp_o.data  = s2_hi_q ? s2_prod_q[2*DataWidth-1:DataWidth] : s2_prod_q[DataWidth-1:0];
  assign resp_o.error = 1'b0;

  // A stalled result must survive until it is taken
  a_s2_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    s2_valid_q && !resp_ready_i |=> s2_valid_q && $stable({s2_id_q, s2_hi_q, s2_prod_q}));

endmodule

// ==== offload_complex.f ====
offload_pkg.sv
spill_register.sv
mul_unit.sv
bitmanip_unit.sv
resp_arbiter.sv
offload_complex.sv
tb_offload_complex.sv

// ==== offload_complex.sv ====
// Offload complex top level with request and response cuts,
// unit steering, multiply and bit units and the response merge
`timescale 1ns/1ps

module offload_complex #(
  parameter bit RegisterReq  = 1'b1,
  parameter bit RegisterResp = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  input  offload_pkg::unit_e  req_unit_i,
  input  logic [1:0]          req_op_i,
  input  offload_pkg::id_t    req_id_i,
  input  logic [31:0]         req_arga_i,
  input  logic [31:0]         req_argb_i,
  output logic                resp_valid_o,
  input  logic                resp_ready_i,
  output offload_pkg::id_t    resp_id_o,
  output logic [31:0]         resp_data_o,
  output logic                resp_error_o
);
  import offload_pkg::*;

  acc_req_t  req_d;
  acc_req_t  req_q;
  logic      req_q_valid;
  logic      req_q_ready;

  logic      mul_req_valid;
  logic      mul_req_ready;
  logic      bit_req_valid;
  logic      bit_req_ready;

  acc_resp_t mul_resp;
  logic      mul_resp_valid;
  logic      mul_resp_ready;
  acc_resp_t bit_resp;
  logic      bit_resp_valid;
  logic      bit_resp_ready;

  acc_resp_t arb_resp;
  logic      arb_resp_valid;
  logic      arb_resp_ready;
  acc_resp_t resp_q;

  assign req_d.unit = req_unit_i;
  assign req_d.op   = req_op_i;
  assign req_d.id   = req_id_i;
  assign req_d.arga = req_arga_i;
  assign req_d.argb = req_argb_i;

  // ------------------------------------------------------------
  // Request cut and steering
  // ------------------------------------------------------------
  spill_register #(
    .T      ( acc_req_t    ),
    .Bypass ( !RegisterReq )
  ) u_req_cut (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_d       ),
    .valid_o ( req_q_valid ),
    .ready_i ( req_q_ready ),
    .data_o  ( req_q       )
  );

  // Valid goes only to the selected unit, both see the payload
  assign mul_req_valid = req_q_valid && (req_q.unit == UnitMul);
  assign bit_req_valid = req_q_valid && (req_q.unit == UnitBit);
  assign req_q_ready   = (req_q.unit == UnitMul) ? mul_req_ready : bit_req_ready;

  mul_unit u_mul_unit (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .req_valid_i  ( mul_req_valid  ),
    .req_ready_o  ( mul_req_ready  ),
    .req_i        ( req_q          ),
    .resp_valid_o ( mul_resp_valid ),
    .resp_ready_i ( mul_resp_ready ),
    .resp_o       ( mul_resp       )
  );

  bitmanip_unit u_bitmanip_unit (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .req_valid_i  ( bit_req_valid  ),
    .req_ready_o  ( bit_req_ready  ),
    .req_i        ( req_q          ),
    .resp_valid_o ( bit_resp_valid ),
    .resp_ready_i ( bit_resp_ready ),
    .resp_o       ( bit_resp       )
  );

  // ------------------------------------------------------------
  // Response merge and cut
  // ------------------------------------------------------------
  resp_arbiter u_resp_arbiter (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .mul_valid_i  ( mul_resp_valid ),
    .mul_ready_o  ( mul_resp_ready ),
    .mul_resp_i   ( mul_resp       ),
    .bit_valid_i  ( bit_resp_valid ),
    .bit_ready_o  ( bit_resp_ready ),
    .bit_resp_i   ( bit_resp       ),
    .resp_valid_o ( arb_resp_valid ),
    .resp_ready_i ( arb_resp_ready ),
    .resp_o       ( arb_resp       )
  );

  spill_register #(
    .T      ( acc_resp_t    ),
    .Bypass ( !RegisterResp )
  ) u_resp_cut (
    .clk_i   ( clk_i          ),
    .rst_i   ( rst_i          ),
    .valid_i ( arb_resp_valid ),
    .ready_o ( arb_resp_ready ),
    .data_i  ( arb_resp       ),
    .valid_o ( resp_valid_o   ),
    .ready_i ( resp_ready_i   ),
    .data_o  ( resp_q         )
  );

  assign resp_id_o    = resp_q.id;
  assign resp_data_o  = resp_q.data;
  assign resp_error_o = resp_q.error;

endmodule

// ==== offload_pkg.sv ====
// Shared widths, operation encodings and payload structs
// for the accelerator offload complex
package offload_pkg;

  localparam int DataWidth = 32;
  localparam int IdWidth   = 5;

  typedef logic [IdWidth-1:0] id_t;

  // Unit select carried in each request
  typedef enum logic {
    UnitMul = 1'b0,
    UnitBit = 1'b1
  } unit_e;

  typedef enum logic [1:0] {
    MulLo   = 2'd0,
    MulHiSS = 2'd1,
    MulHiSU = 2'd2,
    MulHiUU = 2'd3
  } mul_op_e;

  // Code 3 is left undefined and answered with an error
  typedef enum logic [1:0] {
    BitClz  = 2'd0,
    BitCpop = 2'd1,
    BitRol  = 2'd2
  } bit_op_e;

  // ------------------------------------------------------------
  // Stream payloads
  // ------------------------------------------------------------
  typedef struct packed {
    unit_e                unit;
    logic [1:0]           op;
    id_t                  id;
    logic [DataWidth-1:0] arga;
    logic [DataWidth-1:0] argb;
  } acc_req_t;

  typedef struct packed {
    id_t                  id;
    logic [DataWidth-1:0] data;
    logic                 error;
  } acc_resp_t;

endpackage

// ==== resp_arbiter.sv ====
// Round-robin merge of the multiply and bit-manipulation
// response streams, grant held while the output stalls
`timescale 1ns/1ps

module resp_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   mul_valid_i,
  output logic                   mul_ready_o,
  input  offload_pkg::acc_resp_t mul_resp_i,
  input  logic                   bit_valid_i,
  output logic                   bit_ready_o,
  input  offload_pkg::acc_resp_t bit_resp_i,
  output logic                   resp_valid_o,
  input  logic                   resp_ready_i,
  output offload_pkg::acc_resp_t resp_o
);

  // Last grant, 0 for multiply and 1 for bit unit
  logic last_q;
  logic lock_q;
  logic sel;

  always_comb begin
    if (lock_q) begin
      sel = last_q;
    end else if (mul_valid_i && bit_valid_i) begin
      sel = !last_q;
    end else begin
      sel = bit_valid_i;
    end
  end

  assign resp_valid_o = sel ? bit_valid_i : mul_valid_i;
  assign resp_o       = sel ? bit_resp_i : mul_resp_i;
  assign mul_ready_o  = resp_ready_i && !sel;
  assign bit_ready_o  = resp_ready_i && sel;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_q <= 1'b1;
      lock_q <= 1'b0;
    end else if (resp_valid_o) begin
      last_q <= sel;
      // Keep the grant until the stalled response leaves
      lock_q <= !resp_ready_i;
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  a_one_ready : assert property (@(posedge clk_i) disable iff (rst_i)
    !(mul_ready_o && bit_ready_o));

  a_grant_held : assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the offload complex testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_offload_complex \
  -f offload_complex.f \
  -o sim_tb

status=0
out="$(./obj_dir/sim_tb 2>&1)" || status=$?
echo "$out"

if grep -q "TEST OK" <<< "$out"; then
  exit 0
fi
exit 1

// ==== spill_register.sv ====
// Two-entry valid/ready register stage, generic over its payload
// type, with an optional bypass
`timescale 1ns/1ps

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : g_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : g_spill
    logic a_full_q;
    logic b_full_q;
    T     a_data_q;
    T     b_data_q;
    logic a_fill;
    logic a_drain;
    logic b_fill;
    logic b_drain;

    // A takes new input, B catches A when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    // Older entry sits in B whenever B is full
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    a_hold_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o));
  end

endmodule

// ==== tb_offload_complex.sv ====
// Testbench for the offload complex with directed and random requests,
// reference model, scoreboard, per-unit order check and watchdog
`timescale 1ns/1ps

module tb_offload_complex;
  import offload_pkg::*;

  localparam int NumDirected    = 14;
  localparam int NumRandom      = 400;
  localparam int NumReq         = NumDirected + 2 * NumRandom;
  localparam int MaxOutstanding = 16;

  logic        clk_i;
  logic        rst_i;
  logic        req_valid_i;
  logic        req_ready_o;
  unit_e       req_unit_i;
  logic [1:0]  req_op_i;
  id_t         req_id_i;
  logic [31:0] req_arga_i;
  logic [31:0] req_argb_i;
  logic        resp_valid_o;
  logic        resp_ready_i;
  id_t         resp_id_o;
  logic [31:0] resp_data_o;
  logic        resp_error_o;

  // Scoreboard indexed by ID
  logic [DataWidth:0] exp_tab [32];
  logic               unit_tab [32];
  logic               pending [32];
  id_t                mul_order [$];
  id_t                bit_order [$];
  int                 outstanding = 0;
  int                 issued = 0;
  int                 mismatches = 0;
  int                 other_errors = 0;
  int                 seed;
  logic               bp_mode = 1'b0;
  logic [31:0]        bp_next = '1;
  logic               stalled = 1'b0;
  id_t                held_id;
  logic [31:0]        held_data;
  logic               held_error;

  offload_complex #(
    .RegisterReq  ( 1'b1 ),
    .RegisterResp ( 1'b1 )
  ) u_offload_complex (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .req_valid_i  ( req_valid_i  ),
    .req_ready_o  ( req_ready_o  ),
    .req_unit_i   ( req_unit_i   ),
    .req_op_i     ( req_op_i     ),
    .req_id_i     ( req_id_i     ),
    .req_arga_i   ( req_arga_i   ),
    .req_argb_i   ( req_argb_i   ),
    .resp_valid_o ( resp_valid_o ),
    .resp_ready_i ( resp_ready_i ),
    .resp_id_o    ( resp_id_o    ),
    .resp_data_o  ( resp_data_o  ),
    .resp_error_o ( resp_error_o )
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Reference model returning {error, data}
  // ------------------------------------------------------------
  function automatic logic [DataWidth:0] ref_result(input logic unit, input logic [1:0] op,
                                                    input logic [31:0] a, input logic [31:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    logic [31:0] data;
    logic        err;
    int          cnt;
    bit          found;
    int          sh;
    data  = '0;
    err   = 1'b0;
    cnt   = 0;
    found = 1'b0;
    sh    = int'(b[4:0]);
    if (unit == 1'b0) begin
      ext_a = (op == MulHiSS || op == MulHiSU) ? {{32{a[31]}}, a} : {32'b0, a};
      ext_b = (op == MulHiSS) ? {{32{b[31]}}, b} : {32'b0, b};
      prod  = ext_a * ext_b;
      data  = (op == MulLo) ? prod[31:0] : prod[63:32];
    end else begin
      case (op)
        BitClz: begin
          for (int i = 31; i >= 0; i--) begin
            if (a[i]) found = 1'b1;
            else if (!found) cnt++;
          end
          data = 32'(cnt);
        end
        BitCpop: begin
          for (int i = 0; i < 32; i++) begin
            if (a[i]) cnt++;
          end
          data = 32'(cnt);
        end
        BitRol: data = (sh == 0) ? a : ((a << sh) | (a >> (32 - sh)));
        default: err = 1'b1;
      endcase
    end
    return {err, data};
  endfunction

  // ------------------------------------------------------------
  // Request driver
  // ------------------------------------------------------------
  task automatic send_req(input logic unit, input logic [1:0] op,
                          input logic [31:0] a, input logic [31:0] b);
    id_t  id;
    logic accepted;
    id = id_t'(issued);
    while (outstanding >= MaxOutstanding || pending[id]) begin
      @(posedge clk_i);
      #1;
    end
    exp_tab[id]  = ref_result(unit, op, a, b);
    unit_tab[id] = unit;
    pending[id]  = 1'b1;
    outstanding++;
    if (unit) bit_order.push_back(id);
    else mul_order.push_back(id);
    req_unit_i  = unit_e'(unit);
    req_op_i    = op;
    req_id_i    = id;
    req_arga_i  = a;
    req_argb_i  = b;
    req_valid_i = 1'b1;
    // Hold the request until ready is seen before a rising edge
    do begin
      @(negedge clk_i);
      accepted = req_ready_o;
      @(posedge clk_i);
      #1;
    end while (!accepted);
    req_valid_i = 1'b0;
    issued++;
  endtask

  task automatic run_random(input int count);
    logic [31:0] r;
    logic [31:0] a;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      a = (r[6:4] == 3'd0) ? 32'h0 : $random(seed);
      send_req(r[0], r[2:1], a, $random(seed));
    end
  endtask

  task automatic wait_drain();
    while (outstanding != 0) @(posedge clk_i);
    #1;
  endtask

  // ------------------------------------------------------------
  // Compare process
  // ------------------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t signal=%s expected=%h got=%h", $time, name, exp, got);
      mismatches++;
    end
  endtask

  task automatic score_response();
    id_t                id;
    id_t                exp_id;
    logic [DataWidth:0] exp;
    id = resp_id_o;
    assert (pending[id]) else begin
      $display("Response at %0t carries ID %0d with no outstanding request", $time, id);
      other_errors++;
    end
    if (pending[id]) begin
      exp = exp_tab[id];
      compare_value("resp_data_o", exp[31:0], resp_data_o);
      compare_value("resp_error_o", {31'b0, exp[32]}, {31'b0, resp_error_o});
      exp_id = unit_tab[id] ? bit_order.pop_front() : mul_order.pop_front();
      assert (exp_id == id) else begin
        $display("Order broken at %0t in unit %0d, ID %0d returned before ID %0d",
                 $time, unit_tab[id], id, exp_id);
        other_errors++;
      end
      pending[id] = 1'b0;
      outstanding--;
    end
  endtask

  // Response monitor sampling between rising edges
  always @(negedge clk_i) begin
    if (rst_i) begin
      stalled = 1'b0;
    end else begin
      if (stalled) begin
        assert (resp_valid_o) else begin
          $display("Stalled response withdrawn at %0t", $time);
          other_errors++;
        end
        compare_value("resp_id_o", {27'b0, held_id}, {27'b0, resp_id_o});
        compare_value("resp_data_o", held_data, resp_data_o);
        compare_value("resp_error_o", {31'b0, held_error}, {31'b0, resp_error_o});
      end
      if (resp_valid_o && resp_ready_i) score_response();
      stalled    = resp_valid_o && !resp_ready_i;
      held_id    = resp_id_o;
      held_data  = resp_data_o;
      held_error = resp_error_o;
    end
  end

  // Back-pressure drawn between edges and applied after the rising edge
  always @(negedge clk_i) bp_next = $random(seed);

  always @(posedge clk_i) begin
    #1;
    resp_ready_i = bp_mode ? bp_next[0] : 1'b1;
  end

  initial begin
    repeat (NumReq * 20 + 1000) @(posedge clk_i);
    $display("Watchdog expired with %0d responses outstanding", outstanding);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    seed         = 32'heb37;
    rst_i        = 1'b1;
    req_valid_i  = 1'b0;
    req_unit_i   = UnitMul;
    req_op_i     = 2'd0;
    req_id_i     = '0;
    req_arga_i   = '0;
    req_argb_i   = '0;
    resp_ready_i = 1'b1;
    for (int i = 0; i < 32; i++) pending[i] = 1'b0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!resp_valid_o && req_ready_o) else begin
      $display("After reset resp_valid_o=%b req_ready_o=%b", resp_valid_o, req_ready_o);
      other_errors++;
    end
    @(posedge clk_i);
    #1;

    // Directed multiplies on sign-edge operands
    send_req(1'b0, MulLo,   32'h8000_0000, 32'hffff_ffff);
    send_req(1'b0, MulHiSS, 32'h8000_0000, 32'hffff_ffff);
    send_req(1'b0, MulHiSU, 32'h8000_0000, 32'hffff_ffff);
    send_req(1'b0, MulHiUU, 32'h8000_0000, 32'hffff_ffff);
    send_req(1'b0, MulHiSS, 32'h7fff_ffff, 32'h7fff_ffff);
    send_req(1'b0, MulHiUU, 32'hffff_ffff, 32'hffff_ffff);
    send_req(1'b0, MulHiSU, 32'hffff_ffff, 32'h8000_0000);
    send_req(1'b0, MulLo,   32'h1234_5678, 32'h9abc_def0);
    // Directed bit operations including the undefined op code 3
    send_req(1'b1, BitClz,  32'h0000_0000, 32'h0);
    send_req(1'b1, BitClz,  32'h0000_0001, 32'h0);
    send_req(1'b1, BitCpop, 32'hffff_ffff, 32'h0);
    send_req(1'b1, BitRol,  32'h8123_4567, 32'h0000_0000);
    send_req(1'b1, BitRol,  32'h8123_4567, 32'hffff_ffff);
    send_req(1'b1, 2'd3,    32'hdead_beef, 32'h1);
    wait_drain();

    run_random(NumRandom);
    wait_drain();
    bp_mode = 1'b1;
    run_random(NumRandom);
    wait_drain();
    bp_mode = 1'b0;

    $display("Checked %0d requests, %0d mismatches, %0d other errors",
             issued, mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
